//--- include/loader_model.svh
`ifndef LOADER_MODEL_SVH
`define LOADER_MODEL_SVH

// one expected weight memory write
typedef struct packed
{
	logic      is_fc;
	mem_addr_t addr;
	bank_sel_t bank;
	word_t     word;
	logic      done;
	layer_id_t layer;
	logic      loaded;
} weight_event_t;

// one expected pixel memory write
typedef struct packed
{
	mem_addr_t addr;
	word_t     word;
	logic      done;
} pixel_event_t;

// layers arrive in the order 1, 2, 4, 5, 7
localparam int LAYER_WORDS [5] = '{L1_WEIGHTS, L2_WEIGHTS, L4_WEIGHTS, L5_WEIGHTS, L7_WEIGHTS};
localparam int LAYER_NUM [5]   = '{1, 2, 4, 5, 7};

weight_event_t weight_q[$];
pixel_event_t  pixel_q[$];
int            layer_idx;
int            weight_cnt;
int            pixel_cnt;

task automatic model_reset();
	weight_q.delete();
	pixel_q.delete();
	layer_idx  = 0;
	weight_cnt = 0;
	pixel_cnt  = 0;
endtask

function automatic void predict_weight(input word_t w);
	weight_event_t e;
	// once all five layers are in, writes are dropped
	if (layer_idx < 5)
	begin
		e.is_fc  = (LAYER_NUM[layer_idx] == 7);
		e.addr   = e.is_fc ? mem_addr_t'(weight_cnt % FC_BANK_WORDS) : mem_addr_t'(weight_cnt);
		e.bank   = bank_sel_t'(weight_cnt / FC_BANK_WORDS + 1);
		e.word   = w;
		e.done   = (weight_cnt == LAYER_WORDS[layer_idx] - 1);
		e.layer  = layer_id_t'(LAYER_NUM[layer_idx]);
		e.loaded = e.done && (layer_idx == 4);
		weight_q.push_back(e);
		weight_cnt++;
		if (e.done)
		begin
			weight_cnt = 0;
			layer_idx++;
		end
	end
endfunction

function automatic void predict_pixel(input word_t w);
	pixel_event_t e;
	e.addr = mem_addr_t'(pixel_cnt);
	e.word = w;
	e.done = (pixel_cnt == IMAGE_PIXELS - 1);
	pixel_q.push_back(e);
	// wrap for the next image
	pixel_cnt = e.done ? 0 : pixel_cnt + 1;
endfunction

// unmapped regions produce nothing
function automatic void predict_write(input bus_addr_t addr, input bus_data_t data);
	if (addr[31:16] == WEIGHT_REGION)
		predict_weight(data[15:0]);
	else if (addr[31:16] == PIXEL_REGION)
		predict_pixel(data[15:0]);
endfunction

`endif

//--- bench/tb_cnn_param_loader.sv
`timescale 1ns/10ps

module tb_cnn_param_loader
	import cnn_loader_pkg::*;
;

	logic      clk = 1'b0;
	logic      rst;
	logic      host_req;
	bus_addr_t host_addr;
	bus_data_t host_data;
	logic      host_ack;
	logic      conv_weight_write;
	mem_addr_t conv_weight_addr;
	logic      fc_weight_write;
	bank_sel_t fc_bank;
	mem_addr_t fc_weight_addr;
	word_t     weight_word;
	logic      weight_layer_done;
	layer_id_t weight_done_layer;
	logic      weights_loaded;
	logic      pixel_write;
	mem_addr_t pixel_addr;
	word_t     pixel_word;
	logic      image_done;

	int error_count = 0;
	int test_start_errors = 0;
	int tests_run = 0;
	int tests_failed = 0;

	`include "loader_model.svh"

	cnn_param_loader i_cnn_param_loader (.*);

	always #4 clk = ~clk;

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
		begin
			$display("ERROR t=%0t %s expected %0h actual %0h", $time, name, expected, actual);
			error_count++;
		end
	endtask

	task automatic report_failure(input string what);
		$display("failure at %0t: %s", $time, what);
		error_count++;
	endtask

	task automatic abort_on_timeout(input string what);
		$display("timeout at %0t: %s", $time, what);
		$display("CHECKS FAILED");
		$finish;
	endtask

	task automatic apply_reset();
		rst = 1'b1;
		repeat (16) @(negedge clk);
		rst = 1'b0;
		model_reset();
	endtask

	// one full four-phase write, req held a random extra 0 to 2 cycles
	task automatic host_write(input bus_addr_t addr, input bus_data_t data);
		int n;
		int hold;
		hold = $urandom % 3;
		@(negedge clk);
		check_value("host_ack", 0, host_ack);
		host_addr = addr;
		host_data = data;
		host_req  = 1'b1;
		predict_write(addr, data);
		n = 0;
		while (!host_ack && n < 20)
		begin
			@(negedge clk);
			n++;
		end
		if (!host_ack)
			abort_on_timeout("host_ack never rose after host_req");
		else
		begin
			repeat (hold)
			begin
				@(negedge clk);
				check_value("host_ack", 1, host_ack);
			end
			host_req = 1'b0;
			n = 0;
			while (host_ack && n < 20)
			begin
				@(negedge clk);
				n++;
			end
			if (host_ack)
				abort_on_timeout("host_ack stayed high after host_req dropped");
		end
	endtask

	task automatic end_test(input string name);
		repeat (3) @(negedge clk);
		if (weight_q.size() != 0 || pixel_q.size() != 0)
			report_failure("expected memory writes never appeared");
		tests_run++;
		if (error_count != test_start_errors)
		begin
			tests_failed++;
			$display("test %s: fail", name);
		end
		else
			$display("test %s: pass", name);
		test_start_errors = error_count;
	endtask

	task automatic check_weight_write();
		weight_event_t e;
		if (weight_q.size() == 0)
			report_failure("weight write strobe with no write expected");
		else
		begin
			e = weight_q.pop_front();
			check_value("conv_weight_write", e.is_fc ? 0 : 1, conv_weight_write);
			check_value("fc_weight_write", e.is_fc, fc_weight_write);
			if (e.is_fc)
			begin
				check_value("fc_bank", e.bank, fc_bank);
				check_value("fc_weight_addr", e.addr, fc_weight_addr);
			end
			else
				check_value("conv_weight_addr", e.addr, conv_weight_addr);
			check_value("weight_word", e.word, weight_word);
			check_value("weight_layer_done", e.done, weight_layer_done);
			if (e.done)
				check_value("weight_done_layer", e.layer, weight_done_layer);
			check_value("weights_loaded", e.loaded, weights_loaded);
		end
	endtask

	task automatic check_pixel_write();
		pixel_event_t e;
		if (pixel_q.size() == 0)
			report_failure("pixel write strobe with no write expected");
		else
		begin
			e = pixel_q.pop_front();
			check_value("pixel_addr", e.addr, pixel_addr);
			check_value("pixel_word", e.word, pixel_word);
			check_value("image_done", e.done, image_done);
		end
	endtask

	// outputs are registered, so the falling edge sees them settled
	always @(negedge clk)
	begin
		if (!rst)
		begin
			if (conv_weight_write || fc_weight_write)
				check_weight_write();
			else if (weight_layer_done)
				report_failure("weight_layer_done pulsed without a weight write");
			if (pixel_write)
				check_pixel_write();
			else if (image_done)
				report_failure("image_done pulsed without a pixel write");
		end
	end

	initial
	begin
		bit [15:0] tag;
		int        sel;
		void'($urandom(48));
		host_req  = 1'b0;
		host_addr = '0;
		host_data = '0;
		apply_reset();

		check_value("host_ack", 0, host_ack);
		check_value("conv_weight_write", 0, conv_weight_write);
		check_value("fc_weight_write", 0, fc_weight_write);
		check_value("pixel_write", 0, pixel_write);
		check_value("weight_layer_done", 0, weight_layer_done);
		check_value("image_done", 0, image_done);
		check_value("weights_loaded", 0, weights_loaded);
		end_test("reset_state");

		// weight, pixel or unmapped region at random
		for (int i = 0; i < 40; i++)
		begin
			sel = $urandom % 3;
			do
				tag = 16'($urandom);
			while (tag == WEIGHT_REGION || tag == PIXEL_REGION);
			if (sel == 0)
				tag = WEIGHT_REGION;
			else if (sel == 1)
				tag = PIXEL_REGION;
			host_write({tag, 16'($urandom)}, $urandom);
		end
		end_test("handshake");

		apply_reset();
		// one full image plus the start of a second
		for (int i = 0; i < IMAGE_PIXELS + 100; i++)
			host_write({PIXEL_REGION, 16'(i)}, $urandom);
		end_test("pixel_image");

		for (int i = 0; i < L1_WEIGHTS + L2_WEIGHTS + L4_WEIGHTS + L5_WEIGHTS; i++)
			host_write({WEIGHT_REGION, 16'(i)}, $urandom);
		end_test("conv_layers");

		for (int i = 0; i < L7_WEIGHTS; i++)
			host_write({WEIGHT_REGION, 16'(i)}, $urandom);
		check_value("weights_loaded", 1, weights_loaded);
		// extra writes past the last layer
		for (int i = 0; i < 8; i++)
			host_write({WEIGHT_REGION, 16'(i)}, $urandom);
		check_value("weights_loaded", 1, weights_loaded);
		end_test("fc_banks");

		apply_reset();
		for (int i = 0; i < 1500; i++)
		begin
			tag = ($urandom % 2) ? PIXEL_REGION : WEIGHT_REGION;
			host_write({tag, 16'($urandom)}, $urandom);
		end
		end_test("mixed_traffic");

		$display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed,
			error_count);
		if (error_count == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

//--- cnn_param_loader.f
+incdir+include
hw/cnn_loader_pkg.sv
hw/host_write_port.sv
hw/weight_load_sequencer.sv
hw/pixel_load_sequencer.sv
hw/cnn_param_loader.sv
bench/tb_cnn_param_loader.sv

//--- hw/cnn_loader_pkg.sv
package cnn_loader_pkg;

	// host bus
	typedef logic [31:0] bus_addr_t;
	typedef logic [31:0] bus_data_t;

	// local memory side
	typedef logic [15:0] word_t;
	typedef logic [15:0] mem_addr_t;

	// only 1, 2, 4, 5 and 7 carry weights
	typedef logic [2:0] layer_id_t;

	// 0 is no bank, banks run 1 to 5
	typedef logic [2:0] bank_sel_t;

	// weights arrive in fixed layer order
	typedef enum logic [2:0]
	{
		load_l1,
		load_l2,
		load_l4,
		load_l5,
		load_l7,
		weights_full
	} weight_state_t;

	// upper address half selects the region
	localparam logic [15:0] WEIGHT_REGION = 16'hd333;
	localparam logic [15:0] PIXEL_REGION  = 16'hd555;

	// words per layer (3x3 kernels for the conv layers)
	localparam int L1_WEIGHTS = 216;
	localparam int L2_WEIGHTS = 576;
	localparam int L4_WEIGHTS = 576;
	localparam int L5_WEIGHTS = 576;
	localparam int L7_WEIGHTS = 2000;

	// fully-connected layer split over equal banks
	localparam int FC_BANK_WORDS = 400;
	localparam int FC_BANKS      = L7_WEIGHTS / FC_BANK_WORDS;

	// one 32x32x3 input image
	localparam int IMAGE_PIXELS = 3072;

endpackage

//--- hw/cnn_param_loader.sv
`timescale 1ns/10ps

module cnn_param_loader
	import cnn_loader_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      host_req,
	input  bus_addr_t host_addr,
	input  bus_data_t host_data,
	output logic      host_ack,
	output logic      conv_weight_write,
	output mem_addr_t conv_weight_addr,
	output logic      fc_weight_write,
	output bank_sel_t fc_bank,
	output mem_addr_t fc_weight_addr,
	output word_t     weight_word,
	output logic      weight_layer_done,
	output layer_id_t weight_done_layer,
	output logic      weights_loaded,
	output logic      pixel_write,
	output mem_addr_t pixel_addr,
	output word_t     pixel_word,
	output logic      image_done
);

	// beat between port stage and sequencers
	logic  beat_weight;
	logic  beat_pixel;
	word_t beat_word;

	host_write_port i_host_write_port (
		.clk         (clk),
		.rst         (rst),
		.host_req    (host_req),
		.host_addr   (host_addr),
		.host_data   (host_data),
		.host_ack    (host_ack),
		.beat_weight (beat_weight),
		.beat_pixel  (beat_pixel),
		.beat_word   (beat_word)
	);

	weight_load_sequencer i_weight_load_sequencer (
		.clk               (clk),
		.rst               (rst),
		.beat_weight       (beat_weight),
		.beat_word         (beat_word),
		.conv_weight_write (conv_weight_write),
		.conv_weight_addr  (conv_weight_addr),
		.fc_weight_write   (fc_weight_write),
		.fc_bank           (fc_bank),
		.fc_weight_addr    (fc_weight_addr),
		.weight_word       (weight_word),
		.weight_layer_done (weight_layer_done),
		.weight_done_layer (weight_done_layer),
		.weights_loaded    (weights_loaded)
	);

	pixel_load_sequencer i_pixel_load_sequencer (
		.clk         (clk),
		.rst         (rst),
		.beat_pixel  (beat_pixel),
		.beat_word   (beat_word),
		.pixel_write (pixel_write),
		.pixel_addr  (pixel_addr),
		.pixel_word  (pixel_word),
		.image_done  (image_done)
	);

endmodule

//--- hw/host_write_port.sv
`timescale 1ns/10ps

module host_write_port
	import cnn_loader_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      host_req,
	input  bus_addr_t host_addr,
	input  bus_data_t host_data,
	output logic      host_ack,
	output logic      beat_weight,
	output logic      beat_pixel,
	output word_t     beat_word
);

	logic        accept;
	logic [15:0] region_tag;

	// new request only counts once the previous ack has dropped
	assign accept = host_req && !host_ack;

	assign region_tag = host_addr[31:16];

	// four-phase sequence and one-cycle beat pulses
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			host_ack    <= 1'b0;
			beat_weight <= 1'b0;
			beat_pixel  <= 1'b0;
		end
		else
		begin
			beat_weight <= accept && (region_tag == WEIGHT_REGION);
			beat_pixel  <= accept && (region_tag == PIXEL_REGION);
			if (accept)
			begin
				host_ack <= 1'b1;
			end
			else if (!host_req)
			begin
				// host has released req, finish the cycle
				host_ack <= 1'b0;
			end
		end
	end

	// unmapped writes still get an ack, they just never raise a beat
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			beat_word <= host_data[15:0];
		end
	end

endmodule

//--- hw/pixel_load_sequencer.sv
`timescale 1ns/10ps

module pixel_load_sequencer
	import cnn_loader_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      beat_pixel,
	input  word_t     beat_word,
	output logic      pixel_write,
	output mem_addr_t pixel_addr,
	output word_t     pixel_word,
	output logic      image_done
);

	mem_addr_t pixel_cnt;
	logic      last_pixel;

	assign last_pixel = (pixel_cnt == mem_addr_t'(IMAGE_PIXELS - 1));

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			pixel_cnt   <= '0;
			pixel_write <= 1'b0;
			image_done  <= 1'b0;
		end
		else
		begin
			pixel_write <= beat_pixel;
			image_done  <= beat_pixel && last_pixel;
			if (beat_pixel)
			begin
				// wrap so the next image starts at address 0
				if (last_pixel)
					pixel_cnt <= '0;
				else
					pixel_cnt <= pixel_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (beat_pixel)
		begin
			pixel_addr <= pixel_cnt;
			pixel_word <= beat_word;
		end
	end

endmodule

//--- hw/weight_load_sequencer.sv
`timescale 1ns/10ps

module weight_load_sequencer
	import cnn_loader_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      beat_weight,
	input  word_t     beat_word,
	output logic      conv_weight_write,
	output mem_addr_t conv_weight_addr,
	output logic      fc_weight_write,
	output bank_sel_t fc_bank,
	output mem_addr_t fc_weight_addr,
	output word_t     weight_word,
	output logic      weight_layer_done,
	output layer_id_t weight_done_layer,
	output logic      weights_loaded
);

	weight_state_t state;
	weight_state_t state_next;
	mem_addr_t     word_cnt;
	mem_addr_t     last_idx;
	layer_id_t     cur_layer;
	bank_sel_t     bank_calc;
	mem_addr_t     offset_calc;
	logic          take;
	logic          last_word;

	// beats after the last layer are dropped
	assign take = beat_weight && (state != weights_full);

	assign last_word = (word_cnt == last_idx);

	// per-layer size, layer number and successor
	always_comb
	begin
		case (state)
			load_l1:
			begin
				last_idx   = mem_addr_t'(L1_WEIGHTS - 1);
				cur_layer  = layer_id_t'(1);
				state_next = load_l2;
			end
			load_l2:
			begin
				last_idx   = mem_addr_t'(L2_WEIGHTS - 1);
				cur_layer  = layer_id_t'(2);
				state_next = load_l4;
			end
			load_l4:
			begin
				last_idx   = mem_addr_t'(L4_WEIGHTS - 1);
				cur_layer  = layer_id_t'(4);
				state_next = load_l5;
			end
			load_l5:
			begin
				last_idx   = mem_addr_t'(L5_WEIGHTS - 1);
				cur_layer  = layer_id_t'(5);
				state_next = load_l7;
			end
			load_l7:
			begin
				last_idx   = mem_addr_t'(L7_WEIGHTS - 1);
				cur_layer  = layer_id_t'(7);
				state_next = weights_full;
			end
			default:
			begin
				last_idx   = '0;
				cur_layer  = layer_id_t'(7);
				state_next = weights_full;
			end
		endcase
	end

	// layer 7 index to bank and offset, compare chain instead of a divider
	always_comb
	begin
		bank_calc   = bank_sel_t'(1);
		offset_calc = word_cnt;
		for (int b = 1; b < FC_BANKS; b++)
		begin
			if (word_cnt >= mem_addr_t'(b * FC_BANK_WORDS))
			begin
				bank_calc   = bank_sel_t'(b + 1);
				offset_calc = word_cnt - mem_addr_t'(b * FC_BANK_WORDS);
			end
		end
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state             <= load_l1;
			word_cnt          <= '0;
			conv_weight_write <= 1'b0;
			fc_weight_write   <= 1'b0;
			weight_layer_done <= 1'b0;
		end
		else
		begin
			conv_weight_write <= take && (state != load_l7);
			fc_weight_write   <= take && (state == load_l7);
			// done goes out together with the layer's last word
			weight_layer_done <= take && last_word;
			if (take)
			begin
				if (last_word)
				begin
					word_cnt <= '0;
					state    <= state_next;
				end
				else
				begin
					word_cnt <= word_cnt + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (take)
		begin
			weight_word       <= beat_word;
			weight_done_layer <= cur_layer;
			if (state == load_l7)
			begin
				fc_bank        <= bank_calc;
				fc_weight_addr <= offset_calc;
			end
			else
			begin
				conv_weight_addr <= word_cnt;
			end
		end
	end

	// rises in the same cycle as the layer 7 done pulse
	assign weights_loaded = (state == weights_full);

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the loader testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
	-f cnn_param_loader.f \
	--top-module tb_cnn_param_loader \
	-o tb_sim

./obj_dir/tb_sim | tee sim.log

if grep -q "CHECKS FAILED" sim.log; then
	echo "simulation reported failures, see sim.log"
	exit 1
fi
echo "simulation log clean"
